//--- Bender.yml
package:
  name: soc

sources:
  - soc_pkg.sv
  - bus_access.sv
  - bram.sv
  - bridge.sv
  - timer.sv
  - soc.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_soc.sv

//--- bram.sv
module bram (
	input  logic                       i_clock,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  logic [soc_pkg::addr_w-1:0] i_address,
	input  logic [soc_pkg::data_w-1:0] i_wdata,
	output logic [soc_pkg::data_w-1:0] o_rdata,
	output logic                       o_ready
);
	import soc_pkg::*;

	logic [data_w-1:0] mem [ram_words];
	logic [ram_addr_w-1:0] index;
	logic access;

	//==================================================
	// Word index and access strobe

	// Byte address to word index
	assign index = i_address[ram_addr_w+1:2];

	// One access per request, the held request is ignored
	// while ready is up
	assign access = i_request && !o_ready;

	//==================================================
	// Storage

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_rw)
				mem[index] <= i_wdata;
			else
				o_rdata <= mem[index];
		end
	end

	// Ready one cycle after the request
	always_ff @(posedge i_clock) begin
		o_ready <= access;
	end

endmodule

//--- bridge.sv
module bridge #(
	parameter bit registered = 1'b1
) (
	input  logic                           i_clock,
	input  logic                           i_rst_n,

	// Near side
	input  logic                           i_request,
	input  logic                           i_rw,
	input  logic [soc_pkg::region_lsb-1:0] i_address,
	input  logic [soc_pkg::data_w-1:0]     i_wdata,
	output logic [soc_pkg::data_w-1:0]     o_rdata,
	output logic                           o_ready,

	// Far side
	output logic                           o_timer_request,
	output logic                           o_far_rw,
	output logic [3:0]                     o_far_offset,
	output logic [soc_pkg::data_w-1:0]     o_far_wdata,
	input  logic [soc_pkg::data_w-1:0]     i_timer_rdata,
	input  logic                           i_timer_ready
);
	import soc_pkg::*;

	bridge_state_e state;
	logic near_rw;
	logic [region_lsb-1:0] near_address;
	logic [data_w-1:0] near_wdata;
	logic [region_lsb-1:0] far_address;
	logic far_active;
	logic timer_sel;
	logic dev_ready;
	logic far_ready;
	logic [data_w-1:0] far_rdata;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= br_idle;
		end else begin
			case (state)
				br_idle: if (i_request) state <= br_far;
				br_far: if (far_ready) state <= br_done;
				default: state <= br_idle;
			endcase
		end
	end

	// Near transfer latch
	always_ff @(posedge i_clock) begin
		if (state == br_idle && i_request) begin
			near_rw <= i_rw;
			near_address <= i_address;
			near_wdata <= i_wdata;
		end
		if (far_active && far_ready)
			o_rdata <= far_rdata;
	end

	//==================================================
	// Far side

	// Unregistered variant issues the far request in the near cycle
	assign far_active = (state == br_far) || (!registered && state == br_idle && i_request);
	assign far_address = registered ? near_address : i_address;

	assign timer_sel = (far_address[dev_msb:dev_lsb] == dev_timer);
	assign o_timer_request = far_active && timer_sel;
	assign o_far_rw = registered ? near_rw : i_rw;
	assign o_far_wdata = registered ? near_wdata : i_wdata;
	assign o_far_offset = far_address[3:0];

	// No such device, answer zero
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			dev_ready <= 1'b0;
		else
			dev_ready <= far_active && !timer_sel && !dev_ready;
	end

	assign far_ready = timer_sel ? i_timer_ready : dev_ready;
	assign far_rdata = timer_sel ? i_timer_rdata : '0;

	assign o_ready = (state == br_done);

	// Near request is still held when ready comes back
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_ready |-> i_request);

	// Timer answers only a far request
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_timer_ready |-> $past(o_timer_request));

endmodule

//--- build.f
soc_pkg.sv
bus_access.sv
bram.sv
bridge.sv
timer.sv
soc.sv
tb_clock.sv
tb_soc.sv

//--- bus_access.sv
module bus_access (
	input  logic                       i_clock,
	input  logic                       i_rst_n,

	// Port A, instruction side, read only
	input  logic                       i_pa_request,
	input  logic [soc_pkg::addr_w-1:0] i_pa_address,
	output logic                       o_pa_ready,
	output logic [soc_pkg::data_w-1:0] o_pa_rdata,

	// Port B, data side
	input  logic                       i_pb_request,
	input  logic                       i_pb_rw,
	input  logic [soc_pkg::addr_w-1:0] i_pb_address,
	input  logic [soc_pkg::data_w-1:0] i_pb_wdata,
	output logic                       o_pb_ready,
	output logic [soc_pkg::data_w-1:0] o_pb_rdata,

	// Internal bus
	output logic                       o_ram_request,
	output logic                       o_bridge_request,
	output logic                       o_bus_rw,
	output logic [soc_pkg::addr_w-1:0] o_bus_address,
	output logic [soc_pkg::data_w-1:0] o_bus_wdata,
	input  logic [soc_pkg::data_w-1:0] i_ram_rdata,
	input  logic                       i_ram_ready,
	input  logic [soc_pkg::data_w-1:0] i_bridge_rdata,
	input  logic                       i_bridge_ready
);
	import soc_pkg::*;

	arb_state_e state;
	logic bus_active;
	logic [region_msb-region_lsb:0] region;
	logic ram_sel;
	logic bridge_sel;
	logic unmapped_ready;
	logic bus_ready;
	logic [data_w-1:0] bus_rdata;

	//==================================================
	// Arbiter, port B has priority

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= arb_idle;
		end else begin
			case (state)
				arb_idle: begin
					if (i_pb_request)
						state <= arb_port_b;
					else if (i_pa_request)
						state <= arb_port_a;
				end
				arb_port_a, arb_port_b: begin
					if (bus_ready)
						state <= arb_idle;
				end
				default: state <= arb_idle;
			endcase
		end
	end

	// Registered bus stage, loaded while idle
	always_ff @(posedge i_clock) begin
		if (state == arb_idle) begin
			if (i_pb_request) begin
				o_bus_rw <= i_pb_rw;
				o_bus_address <= i_pb_address;
				o_bus_wdata <= i_pb_wdata;
			end else begin
				o_bus_rw <= 1'b0;
				o_bus_address <= i_pa_address;
				o_bus_wdata <= '0;
			end
		end
	end

	assign bus_active = (state != arb_idle);

	//==================================================
	// Region decode

	assign region = o_bus_address[region_msb:region_lsb];
	assign ram_sel = (region == region_ram);
	assign bridge_sel = (region == region_bridge);

	assign o_ram_request = bus_active && ram_sel;
	assign o_bridge_request = bus_active && bridge_sel;

	// Unmapped regions answer with zero after one cycle
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= bus_active && !ram_sel && !bridge_sel && !unmapped_ready;
	end

	assign bus_ready = ram_sel ? i_ram_ready : bridge_sel ? i_bridge_ready : unmapped_ready;
	assign bus_rdata = ram_sel ? i_ram_rdata : bridge_sel ? i_bridge_rdata : '0;

	// Return path to the granted port only
	assign o_pa_ready = (state == arb_port_a) && bus_ready;
	assign o_pb_ready = (state == arb_port_b) && bus_ready;
	assign o_pa_rdata = (state == arb_port_a) ? bus_rdata : '0;
	assign o_pb_rdata = (state == arb_port_b) ? bus_rdata : '0;

	// Targets answer only a request of their own
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_ram_ready |-> $past(o_ram_request));

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_bridge_ready |-> o_bridge_request);

endmodule

//--- soc.sv
module soc (
	input  logic                       i_clock,
	input  logic                       i_rst_n,

	// Port A
	input  logic                       i_pa_request,
	input  logic [soc_pkg::addr_w-1:0] i_pa_address,
	output logic                       o_pa_ready,
	output logic [soc_pkg::data_w-1:0] o_pa_rdata,

	// Port B
	input  logic                       i_pb_request,
	input  logic                       i_pb_rw,
	input  logic [soc_pkg::addr_w-1:0] i_pb_address,
	input  logic [soc_pkg::data_w-1:0] i_pb_wdata,
	output logic                       o_pb_ready,
	output logic [soc_pkg::data_w-1:0] o_pb_rdata,

	output logic                       o_timer_irq
);
	import soc_pkg::*;

	logic bus_rw;
	logic [addr_w-1:0] bus_address;
	logic [data_w-1:0] bus_wdata;

	logic ram_request;
	logic [data_w-1:0] ram_rdata;
	logic ram_ready;

	logic bridge_request;
	logic [data_w-1:0] bridge_rdata;
	logic bridge_ready;

	logic timer_request;
	logic far_rw;
	logic [3:0] far_offset;
	logic [data_w-1:0] far_wdata;
	logic [data_w-1:0] timer_rdata;
	logic timer_ready;

	//==================================================
	// Bus

	bus_access bus (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.o_ram_request(ram_request),
		.o_bridge_request(bridge_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_ram_rdata(ram_rdata),
		.i_ram_ready(ram_ready),
		.i_bridge_rdata(bridge_rdata),
		.i_bridge_ready(bridge_ready)
	);

	// RAM at $10000000
	bram ram (
		.i_clock(i_clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	//==================================================
	// Peripheral bridge at $50000000

	bridge #(
		.registered(1'b1)
	) br (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(bridge_request),
		.i_rw(bus_rw),
		.i_address(bus_address[region_lsb-1:0]),
		.i_wdata(bus_wdata),
		.o_rdata(bridge_rdata),
		.o_ready(bridge_ready),
		.o_timer_request(timer_request),
		.o_far_rw(far_rw),
		.o_far_offset(far_offset),
		.o_far_wdata(far_wdata),
		.i_timer_rdata(timer_rdata),
		.i_timer_ready(timer_ready)
	);

	timer tmr (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(timer_request),
		.i_rw(far_rw),
		.i_offset(far_offset),
		.i_wdata(far_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_timer_irq(o_timer_irq)
	);

endmodule

//--- soc_pkg.sv
package soc_pkg;

	//==================================================
	// Bus widths

	localparam int addr_w = 32;
	localparam int data_w = 32;

	//==================================================
	// Near address map

	// Region field of a bus address
	localparam int region_msb = 31;
	localparam int region_lsb = 28;

	localparam logic [region_msb-region_lsb:0] region_ram = 4'h1;
	localparam logic [region_msb-region_lsb:0] region_bridge = 4'h5;

	// Device field on the far side of the bridge
	localparam int dev_msb = 27;
	localparam int dev_lsb = 24;

	localparam logic [dev_msb-dev_lsb:0] dev_timer = 4'h5;

	// On-chip RAM, word indexed by address bits 11:2
	localparam int ram_words = 1024;
	localparam int ram_addr_w = 10;

	//==================================================
	// Timer

	// Counter advances once per this many clocks
	localparam int timer_prescale = 4;
	localparam int timer_presc_w = $clog2(timer_prescale);

	//==================================================
	// State and register encodings

	typedef enum logic [1:0] {
		arb_idle,
		arb_port_a,
		arb_port_b
	} arb_state_e;

	typedef enum logic [1:0] {
		br_idle,
		br_far,
		br_done
	} bridge_state_e;

	// Timer register offsets, address bits 3:2
	typedef enum logic [1:0] {
		tmr_count = 2'd0,
		tmr_compare = 2'd1,
		tmr_control = 2'd2
	} timer_reg_e;

endpackage

//--- tb_clock.sv
module tb_clock #(
	parameter int period_ns = 100
) (
	output logic o_clock
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free running, starts low
	initial begin
		o_clock = 1'b0;
		forever #(period_ns / 2.0) o_clock = ~o_clock;
	end

endmodule

//--- tb_soc.sv
module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_entries = 32;
	localparam bit port_a = 1'b0;
	localparam bit port_b = 1'b1;

	// Entry modes
	localparam int mode_none = 0;
	localparam int mode_with_next = 1;
	localparam int mode_irq_high = 2;
	localparam int mode_irq_low = 3;

	localparam int setup_cycles = 10;
	localparam int irq_test_cycles = 6;

	logic clock;
	logic rst_n;
	logic pa_request;
	logic [31:0] pa_address;
	logic pa_ready;
	logic [31:0] pa_rdata;
	logic pb_request;
	logic pb_rw;
	logic [31:0] pb_address;
	logic [31:0] pb_wdata;
	logic pb_ready;
	logic [31:0] pb_rdata;
	logic timer_irq;

	// Stimulus table
	bit port_tbl [max_entries];
	bit rw_tbl [max_entries];
	logic [31:0] addr_tbl [max_entries];
	logic [31:0] wdata_tbl [max_entries];
	logic [31:0] exp_tbl [max_entries];
	int mode_tbl [max_entries];
	string names [max_entries];
	int entry_count = 0;
	bit table_ready = 1'b0;

	int cycle = 0;

	tb_clock #(.period_ns(100)) clk_gen (.o_clock(clock));

	soc i_soc (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_pa_request(pa_request),
		.i_pa_address(pa_address),
		.o_pa_ready(pa_ready),
		.o_pa_rdata(pa_rdata),
		.i_pb_request(pb_request),
		.i_pb_rw(pb_rw),
		.i_pb_address(pb_address),
		.i_pb_wdata(pb_wdata),
		.o_pb_ready(pb_ready),
		.o_pb_rdata(pb_rdata),
		.o_timer_irq(timer_irq)
	);

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic add_entry(input bit port, input bit rw, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] expected, input int mode,
			input string name);
		port_tbl[entry_count] = port;
		rw_tbl[entry_count] = rw;
		addr_tbl[entry_count] = addr;
		wdata_tbl[entry_count] = wdata;
		exp_tbl[entry_count] = expected;
		mode_tbl[entry_count] = mode;
		names[entry_count] = name;
		entry_count = entry_count + 1;
	endtask

	// One transfer on the entry's port, held until ready
	task automatic run_transfer(input int idx, output logic [31:0] rdata,
			output int ready_cycle);
		logic seen;
		seen = 1'b0;
		@(posedge clock);
		if (port_tbl[idx] == port_a) begin
			pa_request <= 1'b1;
			pa_address <= addr_tbl[idx];
		end else begin
			pb_request <= 1'b1;
			pb_rw <= rw_tbl[idx];
			pb_address <= addr_tbl[idx];
			pb_wdata <= wdata_tbl[idx];
		end
		while (!seen) begin
			@(negedge clock);
			seen = (port_tbl[idx] == port_a) ? pa_ready : pb_ready;
		end
		rdata = (port_tbl[idx] == port_a) ? pa_rdata : pb_rdata;
		ready_cycle = cycle;
		@(posedge clock);
		if (port_tbl[idx] == port_a)
			pa_request <= 1'b0;
		else
			pb_request <= 1'b0;
	endtask

	// Writes return no data
	task automatic check_entry(input int idx, input logic [31:0] rdata);
		if (!rw_tbl[idx])
			check_value(names[idx], exp_tbl[idx], rdata);
	endtask

	task automatic wait_irq(input string name, input logic level);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 3) begin
			@(negedge clock);
			seen = (timer_irq === level);
			n = n + 1;
		end
		check_value({name, " irq"}, level, timer_irq);
	endtask

	task automatic build_table();
		logic [31:0] w [4];
		for (int k = 0; k < 4; k++)
			w[k] = $urandom;
		add_entry(port_b, 1, 32'h1000_0000, w[0], 0, mode_none, "ram write 0");
		add_entry(port_b, 0, 32'h1000_0000, 0, w[0], mode_none, "ram read 0");
		add_entry(port_b, 1, 32'h1000_0004, w[1], 0, mode_none, "ram write 1");
		add_entry(port_b, 0, 32'h1000_0004, 0, w[1], mode_none, "ram read 1");
		add_entry(port_b, 1, 32'h1000_0ffc, w[2], 0, mode_none, "ram write 2");
		add_entry(port_b, 0, 32'h1000_0ffc, 0, w[2], mode_none, "ram read 2");
		add_entry(port_b, 1, 32'h1000_0200, w[3], 0, mode_none, "ram write 3");
		add_entry(port_b, 0, 32'h1000_0200, 0, w[3], mode_none, "ram read 3");
		add_entry(port_a, 0, 32'h1000_0004, 0, w[1], mode_none, "port a read 1");
		add_entry(port_a, 0, 32'h1000_0ffc, 0, w[2], mode_none, "port a read 2");
		// Same cycle requests, B first in the pair
		add_entry(port_b, 0, 32'h1000_0200, 0, w[3], mode_with_next, "pair port b");
		add_entry(port_a, 0, 32'h1000_0000, 0, w[0], mode_none, "pair port a");
		add_entry(port_b, 1, 32'h5500_0004, 32'h0, 0, mode_none, "timer compare zero");
		add_entry(port_b, 1, 32'h5500_0008, 32'h1, 0, mode_irq_high, "timer enable");
		add_entry(port_b, 0, 32'h5500_0004, 0, 32'h0, mode_none, "compare readback");
		add_entry(port_b, 0, 32'h5500_0008, 0, 32'h1, mode_none, "control readback");
		add_entry(port_b, 1, 32'h5500_0004, 32'hffff_ffff, 0, mode_irq_low, "compare max");
		add_entry(port_b, 0, 32'h5500_0004, 0, 32'hffff_ffff, mode_none, "max readback");
		add_entry(port_b, 0, 32'h3000_0000, 0, 32'h0, mode_none, "unmapped region");
		add_entry(port_b, 0, 32'h5200_0000, 0, 32'h0, mode_none, "unmapped device");
	endtask

	//==================================================
	// Watchdog

	initial begin
		wait (table_ready);
		repeat (entry_count * 40 + irq_test_cycles + setup_cycles) @(posedge clock);
		$display("no ready arrived before the time limit");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	//==================================================
	// Main sequence

	initial begin
		int i;
		logic [31:0] data_first;
		logic [31:0] data_second;
		int cycle_first;
		int cycle_second;

		rst_n = 1'b0;
		pa_request = 1'b0;
		pa_address = '0;
		pb_request = 1'b0;
		pb_rw = 1'b0;
		pb_address = '0;
		pb_wdata = '0;

		void'($urandom(15));
		build_table();
		table_ready = 1'b1;

		repeat (2) @(posedge clock);
		rst_n <= 1'b1;

		// Quiet outputs before any request
		repeat (4) begin
			@(negedge clock);
			check_value("idle pa ready", 0, pa_ready);
			check_value("idle pb ready", 0, pb_ready);
			check_value("idle irq", 0, timer_irq);
		end

		i = 0;
		while (i < entry_count) begin
			if (mode_tbl[i] == mode_with_next) begin
				fork
					run_transfer(i, data_first, cycle_first);
					run_transfer(i + 1, data_second, cycle_second);
				join
				check_entry(i, data_first);
				check_entry(i + 1, data_second);
				check_value({names[i], " order"}, 1, cycle_first < cycle_second);
				i = i + 2;
			end else begin
				run_transfer(i, data_first, cycle_first);
				check_entry(i, data_first);
				if (mode_tbl[i] == mode_irq_high)
					wait_irq(names[i], 1'b1);
				else if (mode_tbl[i] == mode_irq_low)
					wait_irq(names[i], 1'b0);
				i = i + 1;
			end
		end

		$display("test passed");
		$finish;
	end

endmodule

//--- timer.sv
module timer (
	input  logic                       i_clock,
	input  logic                       i_rst_n,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  logic [3:0]                 i_offset,
	input  logic [soc_pkg::data_w-1:0] i_wdata,
	output logic [soc_pkg::data_w-1:0] o_rdata,
	output logic                       o_ready,
	output logic                       o_timer_irq
);
	import soc_pkg::*;

	logic [timer_presc_w-1:0] presc;
	logic [data_w-1:0] count;
	logic [data_w-1:0] compare;
	logic enable;
	logic access;
	timer_reg_e reg_sel;
	logic [data_w-1:0] read_value;

	//==================================================
	// Counter

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			presc <= '0;
			count <= '0;
		end else if (enable) begin
			if (presc == timer_presc_w'(timer_prescale - 1)) begin
				presc <= '0;
				count <= count + 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

	// Compare interrupt
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			o_timer_irq <= 1'b0;
		else
			o_timer_irq <= enable && (count >= compare);
	end

	//==================================================
	// Register access

	assign access = i_request && !o_ready;
	assign reg_sel = timer_reg_e'(i_offset[3:2]);

	always_comb begin
		case (reg_sel)
			tmr_count: read_value = count;
			tmr_compare: read_value = compare;
			tmr_control: read_value = {{(data_w-1){1'b0}}, enable};
			default: read_value = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			compare <= '1;
			enable <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			if (access && i_rw) begin
				case (reg_sel)
					tmr_compare: compare <= i_wdata;
					tmr_control: enable <= i_wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access)
			o_rdata <= read_value;
	end

endmodule
